// File: src/ps2_mouse_pkg.sv
// Shared types for the PS/2 mouse receiver; standard 3-byte packets only, no scroll wheel
`default_nettype none

package ps2_mouse_pkg;

  // ----------------------------------------------------------
  // Plain vector types
  // ----------------------------------------------------------
  typedef logic [7:0]         ps2_byte_t;  // One byte off the wire
  typedef logic [11:0]        coord_t;     // Screen coordinate, up to 4096
  typedef logic signed [8:0]  delta_t;     // Header sign bit plus data byte
  typedef logic [2:0]         buttons_t;   // {middle, right, left}

  // ----------------------------------------------------------
  // Movement packet from the assembler
  // ----------------------------------------------------------
  typedef struct packed {
    buttons_t buttons;     // Straight from header bits 2..0
    logic     x_overflow;  // Header bit 6
    logic     y_overflow;  // Header bit 7
    delta_t   dx;          // Positive is right
    delta_t   dy;          // Positive is up, mouse convention
  } mouse_packet_t;

  // Cursor state seen by the user
  typedef struct packed {
    coord_t   x;
    coord_t   y;           // Grows downward
    buttons_t buttons;
  } cursor_t;

  // ----------------------------------------------------------
  // Frame receiver states
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    rx_idle          = 3'h0,  // Waiting for enable or start
    rx_wait_for_data = 3'h1,  // Hunting for the start bit
    rx_data_in       = 3'h2,  // Eight data bits, LSB first
    rx_parity_in     = 3'h3,  // Parity clocked past, not checked
    rx_stop_in       = 3'h4   // Byte handed out on this edge
  } rx_state_e;

endpackage

`default_nettype wire

// File: src/ps2_line_sync.sv
// Lines are asynchronous to clk; edge strobes and data lag the raw lines by 3 clk cycles
`timescale 1ns/1ns
`default_nettype none

module ps2_line_sync (
  input  logic clk,
  input  logic reset,
  input  logic ps2_clk,          // Raw, open collector, idles high
  input  logic ps2_data,         // Raw, idles high
  output logic ps2_clk_posedge,  // One clk cycle wide
  output logic ps2_clk_negedge,  // One clk cycle wide
  output logic ps2_data_sync
);

  // ----------------------------------------------------------
  // Two-flop synchronizers
  // ----------------------------------------------------------
  logic [1:0] clk_sync;   // [1] is the stable copy
  logic [1:0] data_sync;
  logic       clk_hist;   // Last cycle's synchronized clock

  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync  <= 2'b11;  // Idle level, no false edge out of reset
      data_sync <= 2'b11;
      clk_hist  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_hist  <= clk_sync[1];
    end
  end

  // ----------------------------------------------------------
  // Edge strobes, registered
  // ----------------------------------------------------------
  // Data goes through the same register so it stays aligned with the strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      ps2_clk_posedge <= 1'b0;
      ps2_clk_negedge <= 1'b0;
      ps2_data_sync   <= 1'b1;
    end else begin
      ps2_clk_posedge <= clk_sync[1] & ~clk_hist;   // Low to high
      ps2_clk_negedge <= ~clk_sync[1] & clk_hist;   // High to low
      ps2_data_sync   <= data_sync[1];
    end
  end

endmodule

`default_nettype wire

// File: src/ps2_mouse_datain.sv
// Receive only; parity ignored, no timeout, so a broken frame stalls until more clock edges arrive
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_datain
  import ps2_mouse_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wait_for_incoming_data,  // Level, hunt for a start bit
  input  logic      start_receiving_data,    // Start bit already seen elsewhere
  input  logic      ps2_clk_posedge,
  input  logic      ps2_clk_negedge,         // Interface compatibility only
  input  logic      ps2_data,
  output ps2_byte_t received_data,
  output logic      received_data_en         // High for one cycle per byte
);

  // ----------------------------------------------------------
  // State and datapath registers
  // ----------------------------------------------------------
  rx_state_e state;
  rx_state_e state_next;
  logic [2:0] data_count;      // Bits taken so far in rx_data_in
  ps2_byte_t  data_shift_reg;  // Fills from the top, LSB arrives first

  always_ff @(posedge clk) begin
    if (reset) state <= rx_idle;
    else       state <= state_next;
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_next = state;  // Hold by default
    case (state)
      rx_idle: begin
        // Both requests ignored on the cycle a byte goes out
        if (wait_for_incoming_data && !received_data_en)
          state_next = rx_wait_for_data;
        else if (start_receiving_data && !received_data_en)
          state_next = rx_data_in;
      end
      rx_wait_for_data: begin
        if (!ps2_data && ps2_clk_posedge)    // Start bit is low
          state_next = rx_data_in;
        else if (!wait_for_incoming_data)
          state_next = rx_idle;
      end
      rx_data_in: begin
        if ((data_count == 3'd7) && ps2_clk_posedge)
          state_next = rx_parity_in;
      end
      rx_parity_in: begin
        if (ps2_clk_posedge) state_next = rx_stop_in;  // Parity skipped
      end
      rx_stop_in: begin
        if (ps2_clk_posedge) state_next = rx_idle;
      end
      default: state_next = rx_idle;
    endcase
  end

  // ----------------------------------------------------------
  // Bit counter and shifter
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset)
      data_count <= 3'd0;
    else if (state != rx_data_in)
      data_count <= 3'd0;                 // Ready for next frame
    else if (ps2_clk_posedge)
      data_count <= data_count + 3'd1;
  end

  always_ff @(posedge clk) begin
    if ((state == rx_data_in) && ps2_clk_posedge)
      data_shift_reg <= {ps2_data, data_shift_reg[7:1]};
  end

  // ----------------------------------------------------------
  // Output byte and strobe
  // ----------------------------------------------------------
  // Byte is complete once in the stop state, so it is stable before the strobe
  always_ff @(posedge clk) begin
    if (state == rx_stop_in) received_data <= data_shift_reg;
  end

  always_ff @(posedge clk) begin
    if (reset)
      received_data_en <= 1'b0;
    else
      received_data_en <= (state == rx_stop_in) && ps2_clk_posedge;  // Stop edge
  end

endmodule

`default_nettype wire

// File: src/mouse_packet_assembler.sv
// Standard 3-byte mouse packets only; a first byte with bit 3 clear is dropped to regain sync
`timescale 1ns/1ns
`default_nettype none

module mouse_packet_assembler
  import ps2_mouse_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  ps2_byte_t     received_data,
  input  logic          received_data_en,  // Byte valid on this cycle only
  output mouse_packet_t packet,
  output logic          packet_valid       // One cycle with the packet already loaded
);

  // ----------------------------------------------------------
  // Header bit positions
  // ----------------------------------------------------------
  localparam int hdr_sync_bit = 3;  // Always set in a real header
  localparam int hdr_x_sign   = 4;
  localparam int hdr_y_sign   = 5;
  localparam int hdr_x_ovf    = 6;
  localparam int hdr_y_ovf    = 7;

  logic [1:0] byte_idx;  // Position in packet where 0 is the header
  ps2_byte_t  header;    // Held for bytes 1 and 2
  ps2_byte_t  dx_byte;   // Low bits of X movement

  // ----------------------------------------------------------
  // Byte index
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      byte_idx <= 2'd0;
    end else if (received_data_en) begin
      case (byte_idx)
        2'd0:    if (received_data[hdr_sync_bit]) byte_idx <= 2'd1;  // Else drop it
        2'd1:    byte_idx <= 2'd2;
        default: byte_idx <= 2'd0;  // Third byte closes the packet
      endcase
    end
  end

  // Header and X byte held for the packet build
  always_ff @(posedge clk) begin
    if (received_data_en && (byte_idx == 2'd0)) header  <= received_data;
    if (received_data_en && (byte_idx == 2'd1)) dx_byte <= received_data;
  end

  // ----------------------------------------------------------
  // Packet build on the third byte
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (received_data_en && (byte_idx == 2'd2)) begin
      packet.buttons    <= header[2:0];
      packet.x_overflow <= header[hdr_x_ovf];
      packet.y_overflow <= header[hdr_y_ovf];
      packet.dx         <= {header[hdr_x_sign], dx_byte};        // 9-bit two's complement
      packet.dy         <= {header[hdr_y_sign], received_data};
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      packet_valid <= 1'b0;
    else
      packet_valid <= received_data_en && (byte_idx == 2'd2);
  end

endmodule

`default_nettype wire

// File: src/mouse_position_tracker.sv
// Screen sizes up to 4096 per axis; an axis with its overflow flag set does not move
`timescale 1ns/1ns
`default_nettype none

module mouse_position_tracker
  import ps2_mouse_pkg::*;
#(
  parameter int screen_width  = 640,
  parameter int screen_height = 480
) (
  input  logic          clk,
  input  logic          reset,
  input  mouse_packet_t packet,
  input  logic          packet_valid,
  output cursor_t       cursor,
  output logic          cursor_update   // Cursor already holds new value
);

  // ----------------------------------------------------------
  // Bounds, wide enough for coordinate plus or minus 256
  // ----------------------------------------------------------
  localparam logic signed [13:0] x_limit = 14'(screen_width - 1);
  localparam logic signed [13:0] y_limit = 14'(screen_height - 1);

  logic signed [13:0] x_sum;
  logic signed [13:0] y_sum;
  coord_t             x_next;
  coord_t             y_next;

  always_comb begin
    x_sum = $signed({2'b00, cursor.x}) + $signed({{5{packet.dx[8]}}, packet.dx});
    y_sum = $signed({2'b00, cursor.y}) - $signed({{5{packet.dy[8]}}, packet.dy});  // Y down

    // Clamp X
    if (x_sum < 0)            x_next = '0;
    else if (x_sum > x_limit) x_next = coord_t'(x_limit);
    else                      x_next = coord_t'(x_sum);

    // Clamp Y
    if (y_sum < 0)            y_next = '0;
    else if (y_sum > y_limit) y_next = coord_t'(y_limit);
    else                      y_next = coord_t'(y_sum);
  end

  // ----------------------------------------------------------
  // Cursor register
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cursor <= '0;              // Origin, nothing pressed
    end else if (packet_valid) begin
      if (!packet.x_overflow) cursor.x <= x_next;
      if (!packet.y_overflow) cursor.y <= y_next;
      cursor.buttons <= packet.buttons;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) cursor_update <= 1'b0;
    else       cursor_update <= packet_valid;
  end

endmodule

`default_nettype wire

// File: src/ps2_mouse_rx_top.sv
// Receive-only mouse front end; the mouse must already be streaming, cursor_update lags 6 cycles
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_rx_top
  import ps2_mouse_pkg::*;
#(
  parameter int screen_width  = 640,
  parameter int screen_height = 480
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    ps2_clk,
  input  logic    ps2_data,
  input  logic    rx_enable,     // Level, keep high for normal streaming
  input  logic    rx_start,      // Skip start bit hunt
  output cursor_t cursor,
  output logic    cursor_update
);

  // ----------------------------------------------------------
  // Stage interconnect
  // ----------------------------------------------------------
  logic          ps2_clk_posedge;
  logic          ps2_clk_negedge;
  logic          ps2_data_sync;
  ps2_byte_t     received_data;
  logic          received_data_en;
  mouse_packet_t packet;
  logic          packet_valid;

  ps2_line_sync u_line_sync (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .ps2_clk_posedge (ps2_clk_posedge),
    .ps2_clk_negedge (ps2_clk_negedge),
    .ps2_data_sync   (ps2_data_sync)
  );

  ps2_mouse_datain u_datain (
    .clk                    (clk),
    .reset                  (reset),
    .wait_for_incoming_data (rx_enable),
    .start_receiving_data   (rx_start),
    .ps2_clk_posedge        (ps2_clk_posedge),
    .ps2_clk_negedge        (ps2_clk_negedge),
    .ps2_data               (ps2_data_sync),
    .received_data          (received_data),
    .received_data_en       (received_data_en)
  );

  mouse_packet_assembler u_assembler (
    .clk              (clk),
    .reset            (reset),
    .received_data    (received_data),
    .received_data_en (received_data_en),
    .packet           (packet),
    .packet_valid     (packet_valid)
  );

  mouse_position_tracker #(
    .screen_width  (screen_width),
    .screen_height (screen_height)
  ) u_tracker (
    .clk           (clk),
    .reset         (reset),
    .packet        (packet),
    .packet_valid  (packet_valid),
    .cursor        (cursor),
    .cursor_update (cursor_update)
  );

endmodule

`default_nettype wire

// File: verification/ps2_mouse_rx_checker.sv
// Bound into the receiver top level; reads its internal received_data_en net by name
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_rx_checker
  import ps2_mouse_pkg::*;
#(
  parameter int screen_width  = 640,
  parameter int screen_height = 480
) (
  input logic    clk,
  input logic    reset,
  input cursor_t cursor,
  input logic    cursor_update,
  input logic    received_data_en   // Receiver byte strobe
);

  // ----------------------------------------------------------
  // Strobe shape and cursor bounds
  // ----------------------------------------------------------
  update_single_cycle: assert property (@(posedge clk) disable iff (reset)
    cursor_update |=> !cursor_update)
    else $error("cursor_update held for two cycles");

  cursor_in_bounds: assert property (@(posedge clk) disable iff (reset)
    (int'(cursor.x) < screen_width) && (int'(cursor.y) < screen_height))
    else $error("cursor outside the screen");

  // Byte strobe, packet_valid, then the update
  update_after_byte: assert property (@(posedge clk) disable iff (reset)
    cursor_update |-> $past(received_data_en, 2))
    else $error("cursor_update without a receiver strobe two cycles before");

endmodule

bind ps2_mouse_rx_top ps2_mouse_rx_checker #(
  .screen_width  (screen_width),
  .screen_height (screen_height)
) u_checker (
  .clk              (clk),
  .reset            (reset),
  .cursor           (cursor),
  .cursor_update    (cursor_update),
  .received_data_en (received_data_en)
);

`default_nettype wire

// File: verification/ps2_mouse_rx_tb.sv
// Run from the project root so the data path resolves; expected values assume a 640x480 screen
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_rx_tb
  import ps2_mouse_pkg::*;
;

  // ----------------------------------------------------------
  // DUT signals and bookkeeping
  // ----------------------------------------------------------
  localparam int max_lines = 32;         // Data file capacity, 8 words per line
  localparam int update_timeout = 400;

  logic    clk = 1'b0;
  logic    reset;
  logic    ps2_clk;
  logic    ps2_data;
  logic    rx_enable;
  logic    rx_start;
  cursor_t cursor;
  logic    cursor_update;

  logic [15:0] tdata [256];              // flag, stray, b0, b1, b2, x, y, buttons
  logic [31:0] lfsr;
  cursor_t     last_cursor;              // Cursor seen with the last update strobe
  int          update_count = 0;
  int          expected_updates = 0;
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  logic        timed_out = 1'b0;
  int          line;
  logic [7:0]  idx;

  ps2_mouse_rx_top DUT (
    .clk           (clk),
    .reset         (reset),
    .ps2_clk       (ps2_clk),
    .ps2_data      (ps2_data),
    .rx_enable     (rx_enable),
    .rx_start      (rx_start),
    .cursor        (cursor),
    .cursor_update (cursor_update)
  );

  always #20 clk = ~clk;                 // 40 ns period

  // Old values are read here, before this edge's register updates
  always @(posedge clk) begin
    if (cursor_update) begin
      update_count = update_count + 1;
      last_cursor  = cursor;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #5;                                  // Drive point after the edge
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ 32'h80200003;  // Galois taps 32,22,2,1
    else          return state >> 1;
  endfunction

  task automatic idle_gap();
    logic [3:0] gap;
    gap = 4'd0;
    repeat (4) begin                     // One step per bit taken
      gap  = {gap[2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    if (gap != 4'd0) wait_cycles(int'(gap));
  endtask

  // Start, 8 data bits LSB first, odd parity, stop
  task automatic send_frame(input ps2_byte_t value);
    logic [10:0] bits;
    bits = {1'b1, ~^value, value, 1'b0};
    repeat (11) begin
      ps2_clk = 1'b0;                    // Falling edge
      wait_cycles(1);
      ps2_data = bits[0];                // Data moves just after the fall
      bits = bits >> 1;
      wait_cycles(7);
      ps2_clk = 1'b1;                    // Receiver samples on the rise
      wait_cycles(8);
    end
  endtask

  task automatic wait_for_update(input int target);
    int cycles;
    cycles = 0;
    while ((update_count < target) && (cycles < update_timeout)) begin
      wait_cycles(1);
      cycles++;
    end
    if (update_count < target) begin
      timed_out = 1'b1;
      timeouts++;
      $display("timeout: no cursor_update within %0d cycles for data line %0d",
               update_timeout, line);
    end
  endtask

  task automatic compare_value(input string name, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    reset     = 1'b1;
    ps2_clk   = 1'b1;                    // Bus idle high
    ps2_data  = 1'b1;
    rx_enable = 1'b1;                    // Normal streaming
    rx_start  = 1'b0;
    lfsr      = 32'h3678;
    $readmemh("verification/ps2_mouse_rx_testdata.txt", tdata);
    repeat (5) @(posedge clk);
    #5 reset = 1'b0;

    // Reset state, then silence on the bus
    compare_value("cursor.x", 0, int'(cursor.x));
    compare_value("cursor.y", 0, int'(cursor.y));
    compare_value("cursor.buttons", 0, int'(cursor.buttons));
    wait_cycles(40);
    compare_value("update count", 0, update_count);

    line = 0;
    idx  = 8'd0;
    while ((line < max_lines) && (tdata[idx] != 16'h000F) && !timed_out) begin
      if (tdata[idx] == 16'h0001) begin  // Stray byte ahead of the packet
        send_frame(tdata[idx + 8'd1][7:0]);
        idle_gap();
      end
      send_frame(tdata[idx + 8'd2][7:0]);
      idle_gap();
      send_frame(tdata[idx + 8'd3][7:0]);
      idle_gap();
      send_frame(tdata[idx + 8'd4][7:0]);
      expected_updates++;
      wait_for_update(expected_updates);
      if (!timed_out) begin
        compare_value("cursor.x", int'(tdata[idx + 8'd5]), int'(last_cursor.x));
        compare_value("cursor.y", int'(tdata[idx + 8'd6]), int'(last_cursor.y));
        compare_value("cursor.buttons", int'(tdata[idx + 8'd7]),
                      int'(last_cursor.buttons));
        compare_value("update count", expected_updates, update_count);
      end
      idle_gap();
      line++;
      idx = 8'(line * 8);
    end

    $display("packets %0d, checks %0d, errors %0d, timeouts %0d",
             line, checks, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/ps2_mouse_rx_testdata.txt
// Columns in hex: stray_flag stray_byte byte0 byte1 byte2 exp_x exp_y exp_buttons
// Flag 1 sends the stray byte first; flag F ends the list
0 00 28 14 E2 014 01E 0
0 00 08 05 0A 019 014 0
0 00 18 FB 00 014 014 0
0 00 38 F6 FB 00A 019 0
0 00 18 00 7F 000 000 0
0 00 18 00 FF 000 000 0
0 00 28 FF 01 0FF 0FF 0
0 00 28 FF 01 1FE 1DF 0
0 00 28 FF 01 27F 1DF 0
0 00 48 10 32 27F 1AD 0
0 00 98 CE 40 24D 1AD 0
0 00 09 00 00 24D 1AD 1
0 00 0A 00 00 24D 1AD 2
0 00 0C 00 00 24D 1AD 4
0 00 0B 00 00 24D 1AD 3
0 00 0D 00 00 24D 1AD 5
0 00 0E 00 00 24D 1AD 6
0 00 0F 00 00 24D 1AD 7
1 25 08 01 01 24E 1AC 0
1 42 3A FF FE 24D 1AE 2
F 00 00 00 00 000 000 0

// File: ps2_mouse_rx.f
src/ps2_mouse_pkg.sv
src/ps2_line_sync.sv
src/ps2_mouse_datain.sv
src/mouse_packet_assembler.sv
src/mouse_position_tracker.sv
src/ps2_mouse_rx_top.sv
verification/ps2_mouse_rx_checker.sv
verification/ps2_mouse_rx_tb.sv

// File: Makefile
# Verilator simulation of the PS/2 mouse receiver
.PHONY: help test clean

LOG := sim.log

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f ps2_mouse_rx.f \
	  --top-module ps2_mouse_rx_tb -Mdir obj_dir -o ps2_mouse_rx_sim
	./obj_dir/ps2_mouse_rx_sim 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	elif ! grep -q '\*\* PASS \*\*' $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
